/* verilog/median_filter_pkg.sv */
`default_nettype none

package median_filter_pkg;

    // Pixel and image geometry
    localparam int PIXEL_W = 8;
    typedef logic [PIXEL_W-1:0] pixel_t;

    localparam int ADDR_W = 12;
    typedef logic [ADDR_W-1:0] pixel_addr_t;

    localparam int DIM_W = 7;
    typedef logic [DIM_W-1:0] dim_t;

    // Host register map
    localparam int MODE_W = 2;
    typedef logic [MODE_W-1:0] mode_t;

    localparam mode_t MODE_PIXEL  = 2'd0;
    localparam mode_t MODE_CTRL   = 2'd1;
    localparam mode_t MODE_WIDTH  = 2'd2;
    localparam mode_t MODE_HEIGHT = 2'd3;

    localparam int BUS_W = 32;
    typedef logic [BUS_W-1:0] bus_t;

    typedef logic [MODE_W+ADDR_W-1:0] host_addr_t;

    // 3x3 window
    localparam int TAPS       = 9;
    localparam int CENTER_TAP = 4;
    typedef logic [3:0] tap_idx_t;

endpackage

`default_nettype wire

/* verilog/pixel_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_ram (
    input  wire                                 CLK,
    input  wire                                 we_i,
    input  wire median_filter_pkg::pixel_addr_t waddr_i,
    input  wire median_filter_pkg::pixel_t      wdata_i,
    input  wire median_filter_pkg::pixel_addr_t raddr_i,
    output median_filter_pkg::pixel_t           rdata_o
);

    median_filter_pkg::pixel_t mem [2**median_filter_pkg::ADDR_W];

    always_ff @(posedge CLK) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

/* verilog/host_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module host_regs (
    input  wire                                CLK,
    input  wire                                RST,
    input  wire median_filter_pkg::bus_t       dina_i,
    input  wire median_filter_pkg::host_addr_t addra_i,
    input  wire                                wea_i,
    input  wire                                ena_i,
    output median_filter_pkg::bus_t            douta_o,
    input  wire                                busy_i,
    input  wire                                done_i,
    output logic                               start_o,
    output median_filter_pkg::dim_t            width_o,
    output median_filter_pkg::dim_t            height_o,
    output logic                               in_we_o,
    output median_filter_pkg::pixel_addr_t     in_waddr_o,
    output median_filter_pkg::pixel_t          in_wdata_o,
    output median_filter_pkg::pixel_addr_t     out_raddr_o,
    input  wire median_filter_pkg::pixel_t     out_rdata_i
);

    median_filter_pkg::mode_t mode;
    median_filter_pkg::mode_t rd_mode_q;
    logic                     rd_pend_q;
    logic                     done_q;
    median_filter_pkg::bus_t  rd_data;
    median_filter_pkg::bus_t  hold_q;

    assign mode = addra_i[median_filter_pkg::MODE_W+median_filter_pkg::ADDR_W-1:
                          median_filter_pkg::ADDR_W];

    // Image loads are blocked while the filter reads the input memory
    assign in_we_o     = ena_i & wea_i & (mode == median_filter_pkg::MODE_PIXEL) & ~busy_i;
    assign in_waddr_o  = addra_i[median_filter_pkg::ADDR_W-1:0];
    assign in_wdata_o  = dina_i[median_filter_pkg::PIXEL_W-1:0];
    assign out_raddr_o = addra_i[median_filter_pkg::ADDR_W-1:0];

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start_o  <= 1'b0;
            width_o  <= '0;
            height_o <= '0;
        end else if (ena_i && wea_i) begin
            case (mode)
                median_filter_pkg::MODE_CTRL: start_o <= dina_i[0];
                median_filter_pkg::MODE_WIDTH: begin
                    if (!busy_i) begin
                        width_o <= dina_i[median_filter_pkg::DIM_W-1:0];
                    end
                end
                median_filter_pkg::MODE_HEIGHT: begin
                    if (!busy_i) begin
                        height_o <= dina_i[median_filter_pkg::DIM_W-1:0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Read mode and done are captured with the request, aligned to the RAM latency
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            rd_pend_q <= 1'b0;
            rd_mode_q <= median_filter_pkg::MODE_PIXEL;
            done_q    <= 1'b0;
            hold_q    <= '0;
        end else begin
            rd_pend_q <= ena_i & ~wea_i;
            done_q    <= done_i;
            if (ena_i && !wea_i) begin
                rd_mode_q <= mode;
            end
            if (rd_pend_q) begin
                hold_q <= rd_data;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (rd_mode_q)
            median_filter_pkg::MODE_CTRL:  rd_data[0] = done_q;
            median_filter_pkg::MODE_PIXEL: begin
                if (done_q) begin
                    rd_data[median_filter_pkg::PIXEL_W-1:0] = out_rdata_i;
                end
            end
            default: rd_data = '0;
        endcase
    end

    // Fresh data in the cycle after a read, then held until the next one
    assign douta_o = rd_pend_q ? rd_data : hold_q;

endmodule

`default_nettype wire

/* verilog/filter_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module filter_sequencer (
    input  wire                                CLK,
    input  wire                                RST,
    input  wire                                start_i,
    input  wire median_filter_pkg::dim_t       width_i,
    input  wire median_filter_pkg::dim_t       height_i,
    output logic                               busy_o,
    output logic                               done_o,
    output median_filter_pkg::pixel_addr_t     raddr_o,
    output logic                               load_o,
    output median_filter_pkg::tap_idx_t        load_idx_o,
    output logic                               load_pad_o,
    output logic                               sort_start_o,
    input  wire                                sort_done_i,
    input  wire median_filter_pkg::pixel_t     median_i,
    output logic                               out_we_o,
    output median_filter_pkg::pixel_addr_t     out_waddr_o,
    output median_filter_pkg::pixel_t          out_wdata_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_DONE
    } state_t;

    state_t                         state_q;
    median_filter_pkg::dim_t        row_q;
    median_filter_pkg::dim_t        col_q;
    median_filter_pkg::pixel_addr_t row_base_q;
    median_filter_pkg::tap_idx_t    tap_q;
    logic                           fetch_q;

    logic                           last_tap;
    logic                           last_col;
    logic                           last_row;
    logic                           up;
    logic                           down;
    logic                           left;
    logic                           right;
    logic                           pad;
    median_filter_pkg::pixel_addr_t width_ext;
    median_filter_pkg::pixel_addr_t center_addr;
    median_filter_pkg::pixel_addr_t row_addr;

    assign busy_o = (state_q == ST_EXEC);
    assign done_o = (state_q == ST_DONE);

    assign last_tap = (tap_q == median_filter_pkg::tap_idx_t'(median_filter_pkg::TAPS - 1));
    assign last_col = (col_q == width_i - median_filter_pkg::dim_t'(1));
    assign last_row = (row_q == height_i - median_filter_pkg::dim_t'(1));

    // Taps run row by row through the window with 0..2 above and 6..8 below
    assign up    = (tap_q < median_filter_pkg::tap_idx_t'(3));
    assign down  = (tap_q > median_filter_pkg::tap_idx_t'(5));
    assign left  = (tap_q == 4'd0) | (tap_q == 4'd3) | (tap_q == 4'd6);
    assign right = (tap_q == 4'd2) | (tap_q == 4'd5) | (tap_q == 4'd8);

    assign pad = (up & (row_q == '0)) | (down & last_row) |
                 (left & (col_q == '0)) | (right & last_col);

    assign width_ext   = median_filter_pkg::pixel_addr_t'(width_i);
    assign center_addr = row_base_q + median_filter_pkg::pixel_addr_t'(col_q);

    always_comb begin
        if (up) begin
            row_addr = center_addr - width_ext;
        end else if (down) begin
            row_addr = center_addr + width_ext;
        end else begin
            row_addr = center_addr;
        end

        // Padded taps may wrap here since the sorter replaces them with zero
        if (left) begin
            raddr_o = row_addr - median_filter_pkg::pixel_addr_t'(1);
        end else if (right) begin
            raddr_o = row_addr + median_filter_pkg::pixel_addr_t'(1);
        end else begin
            raddr_o = row_addr;
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q    <= ST_IDLE;
            row_q      <= '0;
            col_q      <= '0;
            row_base_q <= '0;
            tap_q      <= '0;
            fetch_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q    <= ST_EXEC;
                        row_q      <= '0;
                        col_q      <= '0;
                        row_base_q <= '0;
                        tap_q      <= '0;
                        fetch_q    <= 1'b1;
                    end
                end
                ST_EXEC: begin
                    if (fetch_q) begin
                        if (last_tap) begin
                            tap_q   <= '0;
                            fetch_q <= 1'b0;
                        end else begin
                            tap_q <= tap_q + 4'd1;
                        end
                    end
                    if (sort_done_i) begin
                        if (!last_col) begin
                            col_q   <= col_q + median_filter_pkg::dim_t'(1);
                            fetch_q <= 1'b1;
                        end else if (!last_row) begin
                            col_q      <= '0;
                            row_q      <= row_q + median_filter_pkg::dim_t'(1);
                            row_base_q <= row_base_q + width_ext;
                            fetch_q    <= 1'b1;
                        end else begin
                            col_q   <= '0;
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    if (!start_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Load strobe trails the tap read by the RAM latency
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            load_o       <= 1'b0;
            load_idx_o   <= '0;
            load_pad_o   <= 1'b0;
            sort_start_o <= 1'b0;
        end else begin
            load_o       <= fetch_q;
            load_idx_o   <= tap_q;
            load_pad_o   <= pad;
            sort_start_o <= load_o &&
                (load_idx_o == median_filter_pkg::tap_idx_t'(median_filter_pkg::TAPS - 1));
        end
    end

    assign out_we_o    = sort_done_i;
    assign out_waddr_o = center_addr;
    assign out_wdata_o = median_i;

endmodule

`default_nettype wire

/* verilog/window_sorter.sv */
`timescale 1ns/100ps
`default_nettype none

module window_sorter (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              load_i,
    input  wire median_filter_pkg::tap_idx_t load_idx_i,
    input  wire                              load_pad_i,
    input  wire median_filter_pkg::pixel_t   load_pixel_i,
    input  wire                              start_i,
    output logic                             done_o,
    output median_filter_pkg::pixel_t        median_o
);

    median_filter_pkg::pixel_t   win_q  [median_filter_pkg::TAPS];
    median_filter_pkg::pixel_t   sorted [median_filter_pkg::TAPS];
    median_filter_pkg::tap_idx_t pass_q;
    median_filter_pkg::tap_idx_t pass;
    logic                        running_q;
    logic                        active;
    logic                        last_pass;

    // The start cycle already runs pass 0
    assign active    = start_i | running_q;
    assign pass      = start_i ? '0 : pass_q;
    assign last_pass = (pass == median_filter_pkg::tap_idx_t'(median_filter_pkg::TAPS - 1));

    // One odd-even transposition pass, even pairs on even passes
    always_comb begin
        sorted = win_q;
        for (int k = 0; k < median_filter_pkg::TAPS - 1; k++) begin
            if ((k[0] == pass[0]) && (win_q[k] > win_q[k+1])) begin
                sorted[k]   = win_q[k+1];
                sorted[k+1] = win_q[k];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load_i) begin
            win_q[load_idx_i] <= load_pad_i ? '0 : load_pixel_i;
        end else if (active) begin
            win_q <= sorted;
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            running_q <= 1'b0;
            pass_q    <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (active) begin
                if (last_pass) begin
                    running_q <= 1'b0;
                    pass_q    <= '0;
                    done_o    <= 1'b1;
                end else begin
                    running_q <= 1'b1;
                    pass_q    <= pass + 4'd1;
                end
            end
        end
    end

    // Nine passes leave the window fully ordered
    assign median_o = win_q[median_filter_pkg::CENTER_TAP];

endmodule

`default_nettype wire

/* verilog/median_filter_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module median_filter_unit (
    input  wire                                CLK,
    input  wire                                RST,
    input  wire median_filter_pkg::bus_t       dina_i,
    input  wire median_filter_pkg::host_addr_t addra_i,
    input  wire                                wea_i,
    input  wire                                ena_i,
    output median_filter_pkg::bus_t            douta_o
);

    logic                           start;
    median_filter_pkg::dim_t        width;
    median_filter_pkg::dim_t        height;
    logic                           busy;
    logic                           done;

    logic                           in_we;
    median_filter_pkg::pixel_addr_t in_waddr;
    median_filter_pkg::pixel_t      in_wdata;
    median_filter_pkg::pixel_addr_t in_raddr;
    median_filter_pkg::pixel_t      in_rdata;

    logic                           out_we;
    median_filter_pkg::pixel_addr_t out_waddr;
    median_filter_pkg::pixel_t      out_wdata;
    median_filter_pkg::pixel_addr_t out_raddr;
    median_filter_pkg::pixel_t      out_rdata;

    logic                           load;
    median_filter_pkg::tap_idx_t    load_idx;
    logic                           load_pad;
    logic                           sort_start;
    logic                           sort_done;
    median_filter_pkg::pixel_t      median;

    host_regs host_regs_i (
        .CLK         (CLK),
        .RST         (RST),
        .dina_i      (dina_i),
        .addra_i     (addra_i),
        .wea_i       (wea_i),
        .ena_i       (ena_i),
        .douta_o     (douta_o),
        .busy_i      (busy),
        .done_i      (done),
        .start_o     (start),
        .width_o     (width),
        .height_o    (height),
        .in_we_o     (in_we),
        .in_waddr_o  (in_waddr),
        .in_wdata_o  (in_wdata),
        .out_raddr_o (out_raddr),
        .out_rdata_i (out_rdata)
    );

    pixel_ram in_ram_i (
        .CLK     (CLK),
        .we_i    (in_we),
        .waddr_i (in_waddr),
        .wdata_i (in_wdata),
        .raddr_i (in_raddr),
        .rdata_o (in_rdata)
    );

    pixel_ram out_ram_i (
        .CLK     (CLK),
        .we_i    (out_we),
        .waddr_i (out_waddr),
        .wdata_i (out_wdata),
        .raddr_i (out_raddr),
        .rdata_o (out_rdata)
    );

    filter_sequencer filter_sequencer_i (
        .CLK          (CLK),
        .RST          (RST),
        .start_i      (start),
        .width_i      (width),
        .height_i     (height),
        .busy_o       (busy),
        .done_o       (done),
        .raddr_o      (in_raddr),
        .load_o       (load),
        .load_idx_o   (load_idx),
        .load_pad_o   (load_pad),
        .sort_start_o (sort_start),
        .sort_done_i  (sort_done),
        .median_i     (median),
        .out_we_o     (out_we),
        .out_waddr_o  (out_waddr),
        .out_wdata_o  (out_wdata)
    );

    window_sorter window_sorter_i (
        .CLK          (CLK),
        .RST          (RST),
        .load_i       (load),
        .load_idx_i   (load_idx),
        .load_pad_i   (load_pad),
        .load_pixel_i (in_rdata),
        .start_i      (sort_start),
        .done_o       (sort_done),
        .median_o     (median)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Active low reset, released on a rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/median_filter_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module median_filter_assertions (
    input wire                          CLK,
    input wire                          RST,
    input wire                          busy_i,
    input wire                          done_i,
    input wire                          out_we_i,
    input wire                          sort_start_i,
    input wire                          sort_done_i,
    input wire median_filter_pkg::bus_t douta_i
);

    int unsigned failures = 0;

    // Busy and done are separate FSM states
    busy_done_apart: assert property (@(posedge CLK) disable iff (!RST) !(busy_i && done_i))
        else begin
            failures++;
            $error("busy and done are high in the same cycle");
        end

    out_write_in_busy: assert property (@(posedge CLK) disable iff (!RST) out_we_i |-> busy_i)
        else begin
            failures++;
            $error("output memory written outside the busy state");
        end

    // Sorter latency in both directions
    sort_done_on_time: assert property (@(posedge CLK) disable iff (!RST)
        $past(sort_start_i, median_filter_pkg::TAPS) |-> sort_done_i)
        else begin
            failures++;
            $error("sort done missing after sort start");
        end

    sort_done_has_start: assert property (@(posedge CLK) disable iff (!RST)
        sort_done_i |-> $past(sort_start_i, median_filter_pkg::TAPS))
        else begin
            failures++;
            $error("sort done without a matching sort start");
        end

    douta_known: assert property (@(posedge CLK) disable iff (!RST) !$isunknown(douta_i))
        else begin
            failures++;
            $error("host read data is unknown");
        end

endmodule

bind median_filter_unit median_filter_assertions assertions_i (
    .CLK          (CLK),
    .RST          (RST),
    .busy_i       (busy),
    .done_i       (done),
    .out_we_i     (out_we),
    .sort_start_i (sort_start),
    .sort_done_i  (sort_done),
    .douta_i      (douta_o)
);

`default_nettype wire

/* verification/median_filter_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module median_filter_tb;

    localparam int CYCLES_PER_PIXEL = 40;
    localparam int MARGIN_CYCLES    = 2000;
    localparam int MAX_CASES        = 16;
    localparam int RAND_W           = 8;
    localparam int RAND_H           = 6;
    localparam int BUSY_WRITES      = 8;

    logic                          CLK;
    logic                          RST;
    median_filter_pkg::bus_t       dina;
    median_filter_pkg::host_addr_t addra;
    logic                          wea;
    logic                          ena;
    median_filter_pkg::bus_t       douta;

    // Pattern cases with the pixels of all cases stored back to back
    string                     case_name [MAX_CASES];
    int                        case_w    [MAX_CASES];
    int                        case_h    [MAX_CASES];
    int                        case_base [MAX_CASES];
    int                        num_cases = 0;
    median_filter_pkg::pixel_t pat_in  [$];
    median_filter_pkg::pixel_t pat_out [$];

    // Image under test and its expected result
    median_filter_pkg::pixel_t img_in  [$];
    median_filter_pkg::pixel_t img_exp [$];

    logic [31:0] lcg_state;
    int          watchdog_cycles = 0;

    tb_clock_gen clock_gen_i (
        .clk_o (CLK),
        .rst_o (RST)
    );

    median_filter_unit dut_i (
        .CLK     (CLK),
        .RST     (RST),
        .dina_i  (dina),
        .addra_i (addra),
        .wea_i   (wea),
        .ena_i   (ena),
        .douta_o (douta)
    );

    function automatic median_filter_pkg::host_addr_t make_addr(
        median_filter_pkg::mode_t mode,
        int                       pix
    );
        return {mode, median_filter_pkg::pixel_addr_t'(pix)};
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Middle of the nine neighbourhood values with zero outside the image
    function automatic median_filter_pkg::pixel_t window_median(int w, int h, int r, int c);
        median_filter_pkg::pixel_t vals [9];
        median_filter_pkg::pixel_t tmp;
        int n;
        int rr;
        int cc;
        n = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                rr = r + dr;
                cc = c + dc;
                if (rr < 0 || rr >= h || cc < 0 || cc >= w) begin
                    vals[n] = '0;
                end else begin
                    vals[n] = img_in[rr * w + cc];
                end
                n++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8 - i; j++) begin
                if (vals[j] > vals[j+1]) begin
                    tmp       = vals[j];
                    vals[j]   = vals[j+1];
                    vals[j+1] = tmp;
                end
            end
        end
        return vals[4];
    endfunction

    task automatic report_bad_file(string what);
        $display("Pattern file error: %s", what);
        $display("** FAIL **");
        $fatal(1, "Cannot use the pattern file");
    endtask

    task automatic compare_pixel(
        string                     test,
        median_filter_pkg::pixel_t exp,
        median_filter_pkg::pixel_t act
    );
        if (act !== exp) begin
            $display("Fail %s: expected %02h, actual %02h", test, exp, act);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic compare_status(
        string                   test,
        median_filter_pkg::bus_t exp,
        median_filter_pkg::bus_t act
    );
        if (act !== exp) begin
            $display("Fail %s: expected %08h, actual %08h", test, exp, act);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic host_write(median_filter_pkg::host_addr_t addr, median_filter_pkg::bus_t data);
        @(posedge CLK);
        ena   <= 1'b1;
        wea   <= 1'b1;
        addra <= addr;
        dina  <= data;
        @(posedge CLK);
        ena <= 1'b0;
        wea <= 1'b0;
    endtask

    // Read data is valid in the cycle after the request
    task automatic host_read(
        median_filter_pkg::host_addr_t  addr,
        output median_filter_pkg::bus_t data
    );
        @(posedge CLK);
        ena   <= 1'b1;
        wea   <= 1'b0;
        addra <= addr;
        @(posedge CLK);
        ena <= 1'b0;
        @(negedge CLK);
        data = douta;
    endtask

    task automatic read_pixel_list(int fd, int count, bit to_expected);
        int v;
        int code;
        for (int i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", v);
            if (code != 1) begin
                report_bad_file("pixel list shorter than width times height");
            end
            if (to_expected) begin
                pat_out.push_back(median_filter_pkg::pixel_t'(v));
            end else begin
                pat_in.push_back(median_filter_pkg::pixel_t'(v));
            end
        end
    endtask

    task automatic read_patterns();
        int             fd;
        int             code;
        int             w;
        int             h;
        string          word;
        logic [255:0]   tok;
        logic [255:0]   name;
        logic [1023:0]  line;
        fd = $fopen("verification/median_filter_patterns.txt", "r");
        if (fd == 0) begin
            report_bad_file("cannot open verification/median_filter_patterns.txt");
        end
        tok  = '0;
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            word = $sformatf("%0s", tok);
            if (word == "#") begin
                code = $fgets(line, fd);
            end else if (word == "case") begin
                name = '0;
                code = $fscanf(fd, "%s %d %d", name, w, h);
                if (code != 3 || num_cases >= MAX_CASES) begin
                    report_bad_file("bad case line or too many cases");
                end
                case_name[num_cases] = $sformatf("%0s", name);
                case_w[num_cases]    = w;
                case_h[num_cases]    = h;
                case_base[num_cases] = pat_in.size();
                num_cases++;
            end else if ((word == "in" || word == "out") && num_cases > 0) begin
                read_pixel_list(fd, case_w[num_cases-1] * case_h[num_cases-1], word == "out");
            end else begin
                report_bad_file({"unexpected token ", word});
            end
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    task automatic select_case(int idx);
        img_in.delete();
        img_exp.delete();
        for (int i = 0; i < case_w[idx] * case_h[idx]; i++) begin
            img_in.push_back(pat_in[case_base[idx] + i]);
            img_exp.push_back(pat_out[case_base[idx] + i]);
        end
    endtask

    task automatic make_random_case();
        img_in.delete();
        img_exp.delete();
        for (int i = 0; i < RAND_W * RAND_H; i++) begin
            lcg_state = lcg_next(lcg_state);
            img_in.push_back(lcg_state[23:16]);
        end
        for (int r = 0; r < RAND_H; r++) begin
            for (int c = 0; c < RAND_W; c++) begin
                img_exp.push_back(window_median(RAND_W, RAND_H, r, c));
            end
        end
    endtask

    task automatic run_case(string name, int w, int h, bit busy_writes);
        median_filter_pkg::bus_t   rd;
        median_filter_pkg::pixel_t inv;
        host_write(make_addr(median_filter_pkg::MODE_WIDTH, 0), median_filter_pkg::bus_t'(w));
        host_write(make_addr(median_filter_pkg::MODE_HEIGHT, 0), median_filter_pkg::bus_t'(h));
        for (int i = 0; i < w * h; i++) begin
            host_write(make_addr(median_filter_pkg::MODE_PIXEL, i),
                       median_filter_pkg::bus_t'(img_in[i]));
        end
        host_write(make_addr(median_filter_pkg::MODE_CTRL, 0), 32'd1);
        // Image writes during the run must be dropped
        if (busy_writes) begin
            for (int i = 0; i < BUSY_WRITES && i < w * h; i++) begin
                inv = ~img_in[i];
                host_write(make_addr(median_filter_pkg::MODE_PIXEL, i),
                           median_filter_pkg::bus_t'(inv));
            end
        end
        do begin
            host_read(make_addr(median_filter_pkg::MODE_CTRL, 0), rd);
        end while (rd[0] !== 1'b1);
        compare_status($sformatf("%s done status", name), 32'd1, rd);
        for (int i = 0; i < w * h; i++) begin
            host_read(make_addr(median_filter_pkg::MODE_PIXEL, i), rd);
            compare_pixel($sformatf("%s pixel %0d", name, i), img_exp[i],
                          rd[median_filter_pkg::PIXEL_W-1:0]);
            compare_status($sformatf("%s pixel %0d upper bits", name, i), '0,
                           rd >> median_filter_pkg::PIXEL_W);
        end
        host_write(make_addr(median_filter_pkg::MODE_CTRL, 0), 32'd0);
        host_read(make_addr(median_filter_pkg::MODE_CTRL, 0), rd);
        compare_status($sformatf("%s status after clear", name), '0, rd);
        host_read(make_addr(median_filter_pkg::MODE_PIXEL, 0), rd);
        compare_status($sformatf("%s pixel after clear", name), '0, rd);
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge CLK);
        $display("Timeout: the filter never signalled done within %0d cycles", watchdog_cycles);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        wait (dut_i.assertions_i.failures != 0);
        $display("A concurrent assertion failed, see the error above");
        $display("** FAIL **");
        $fatal(1, "Assertion failure");
    end

    initial begin
        median_filter_pkg::bus_t rd;
        int                      total_pixels;
        ena       = 1'b0;
        wea       = 1'b0;
        addra     = '0;
        dina      = '0;
        lcg_state = 32'h51c2;
        read_patterns();
        if (num_cases == 0) begin
            report_bad_file("no cases found");
        end

        // Every case plus the random image and the restart run
        total_pixels = RAND_W * RAND_H + case_w[0] * case_h[0];
        for (int i = 0; i < num_cases; i++) begin
            total_pixels += case_w[i] * case_h[i];
        end
        watchdog_cycles = total_pixels * CYCLES_PER_PIXEL + MARGIN_CYCLES;

        wait (RST === 1'b1);
        host_read(make_addr(median_filter_pkg::MODE_CTRL, 0), rd);
        compare_status("reset status", '0, rd);
        host_read(make_addr(median_filter_pkg::MODE_PIXEL, 0), rd);
        compare_status("reset pixel", '0, rd);

        for (int i = 0; i < num_cases; i++) begin
            select_case(i);
            run_case(case_name[i], case_w[i], case_h[i], 1'b0);
        end

        make_random_case();
        run_case("random8x6", RAND_W, RAND_H, 1'b1);

        // Smaller image again after the large one
        select_case(0);
        run_case({"restart_", case_name[0]}, case_w[0], case_h[0], 1'b0);

        if (dut_i.assertions_i.failures == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Concurrent assertions failed %0d times", dut_i.assertions_i.failures);
            $display("** FAIL **");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

`default_nettype wire

/* median_filter.f */
verilog/median_filter_pkg.sv
verilog/pixel_ram.sv
verilog/host_regs.sv
verilog/filter_sequencer.sv
verilog/window_sorter.sv
verilog/median_filter_unit.sv
verification/tb_clock_gen.sv
verification/median_filter_assertions.sv
verification/median_filter_tb.sv

/* Makefile */
# Verilator build and run of the median filter testbench

VERILATOR ?= verilator
TOP       ?= median_filter_tb
FILELIST  ?= median_filter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --top-module $(TOP)
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/median_filter_patterns.txt */
# case <name> <width> <height> then in and out lists of width*height hex pixels
# pixels are row major and a list may continue over several lines
case grid3x3 3 3
in  11 22 33 44 55 66 77 88 99
out 00 22 00 22 55 33 00 55 00
case row1x5 5 1
in  10 20 30 40 50
out 00 00 00 00 00
case col1x4 1 4
in  ff ee dd cc
out 00 00 00 00
case noise4x4 4 4
in  05 80 10 f0
    20 ff 30 40
    00 60 90 a0
    70 08 c0 50
out 00 10 30 00
    05 30 80 30
    08 60 60 40
    00 08 50 00
case ramp5x3 5 3
in  01 02 03 04 05
    06 07 08 09 0a
    0b 0c 0d 0e 0f
out 00 02 03 04 00
    02 07 08 09 05
    00 07 08 09 00
